// ==== alu.sv ====
/*
 * Combinational ALU for all RV32I integer operations
 * Shift amount is the low log2(DWIDTH) bits of b_i
 * LUI passes b_i, AUIPC adds b_i to pc_i
 */
`timescale 1ns/1ps

module alu #(
    parameter int DWIDTH = riscv_isa_pkg::XLEN
) (
    input  riscv_isa_pkg::alu_op_e op_i,
    input  logic [DWIDTH-1:0]      a_i,       // rs1
    input  logic [DWIDTH-1:0]      b_i,       // rs2 or immediate
    input  logic [DWIDTH-1:0]      pc_i,      // For AUIPC
    output logic [DWIDTH-1:0]      res_o
);
    import riscv_isa_pkg::*;

    localparam int SHW = $clog2(DWIDTH);      // 5 for RV32

    logic [SHW-1:0]    shamt;
    logic              lt_s;                  // Signed a < b
    logic              lt_u;                  // Unsigned a < b
    logic [DWIDTH-1:0] sum;
    logic [DWIDTH-1:0] diff;

    assign shamt = b_i[SHW-1:0];
    assign lt_s  = ($signed(a_i) < $signed(b_i));
    assign lt_u  = (a_i < b_i);
    assign sum   = a_i + b_i;
    assign diff  = a_i - b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:   res_o = sum;           // Also load/store/JALR address
            ALU_SUB:   res_o = diff;
            ALU_AND:   res_o = a_i & b_i;
            ALU_OR:    res_o = a_i | b_i;
            ALU_XOR:   res_o = a_i ^ b_i;
            ALU_SLL:   res_o = a_i << shamt;
            ALU_SRL:   res_o = a_i >> shamt;
            ALU_SRA:   res_o = $unsigned($signed(a_i) >>> shamt); // Sign fill
            ALU_SLT:   res_o = {{(DWIDTH-1){1'b0}}, lt_s};
            ALU_SLTU:  res_o = {{(DWIDTH-1){1'b0}}, lt_u};
            ALU_LUI:   res_o = b_i;           // U immediate already shifted
            ALU_AUIPC: res_o = pc_i + b_i;
            default:   res_o = sum;
        endcase
    end

endmodule : alu

// ==== control.sv ====
/*
 * Main decoder, purely combinational
 * Unknown opcodes decode to the no-op bundle
 * Load/store funct3 is ignored, every access is a word
 */
`timescale 1ns/1ps

module control (
    input  riscv_isa_pkg::opcode_e opcode_i,     // Instruction bits [6:0]
    input  logic [2:0]             funct3_i,     // Instruction bits [14:12]
    input  logic [6:0]             funct7_i,     // Instruction bits [31:25]
    output core_ctrl_pkg::ctrl_t   ctrl_o
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    // ALU op from funct3/funct7, shared by R-type and I-type
    function automatic alu_op_e decode_alu(input logic [2:0] f3,
                                           input logic [6:0] f7,
                                           input logic       is_reg);
        logic alt;
        alt = (f7 == FUNCT7_SUB_SRA);             // Bit 30 selects SUB/SRA
        case (f3)
            FUNCT3_ADD_SUB: decode_alu = (alt && is_reg) ? ALU_SUB : ALU_ADD; // No SUBI
            FUNCT3_SLL:     decode_alu = ALU_SLL;
            FUNCT3_SLT:     decode_alu = ALU_SLT;
            FUNCT3_SLTU:    decode_alu = ALU_SLTU;
            FUNCT3_XOR:     decode_alu = ALU_XOR;
            FUNCT3_SRL_SRA: decode_alu = alt ? ALU_SRA : ALU_SRL; // SRAI uses it too
            FUNCT3_OR:      decode_alu = ALU_OR;
            default:        decode_alu = ALU_AND; // FUNCT3_AND
        endcase
    endfunction

    // Branch comparison named by funct3
    function automatic br_op_e decode_br(input logic [2:0] f3);
        case (f3)
            FUNCT3_BEQ:  decode_br = BR_EQ;
            FUNCT3_BNE:  decode_br = BR_NE;
            FUNCT3_BLT:  decode_br = BR_LT;
            FUNCT3_BGE:  decode_br = BR_GE;
            FUNCT3_BLTU: decode_br = BR_LTU;
            FUNCT3_BGEU: decode_br = BR_GEU;
            default:     decode_br = BR_NONE;     // Reserved funct3, falls through
        endcase
    endfunction

    always_comb begin
        ctrl_o = CTRL_NOP;                        // Defaults, also unknown opcodes
        case (opcode_i)
            OPCODE_RTYPE: begin
                ctrl_o.regwren = 1'b1;
                ctrl_o.alu_op  = decode_alu(funct3_i, funct7_i, 1'b1);
            end
            OPCODE_ITYPE: begin
                ctrl_o.regwren  = 1'b1;
                ctrl_o.op_b_imm = 1'b1;
                ctrl_o.alu_op   = decode_alu(funct3_i, funct7_i, 1'b0);
            end
            OPCODE_LOAD: begin
                ctrl_o.regwren  = 1'b1;
                ctrl_o.memren   = 1'b1;
                ctrl_o.op_b_imm = 1'b1;           // Address is rs1 + imm
                ctrl_o.wb_sel   = WB_MEM;
            end
            OPCODE_STORE: begin
                ctrl_o.memwren  = 1'b1;
                ctrl_o.op_b_imm = 1'b1;           // Data comes from rs2 directly
            end
            OPCODE_BRANCH: begin
                ctrl_o.br_op = decode_br(funct3_i); // Compare in pc_unit, ALU unused
            end
            OPCODE_JAL: begin
                ctrl_o.regwren = 1'b1;
                ctrl_o.br_op   = BR_JAL;          // Target is PC + imm
                ctrl_o.wb_sel  = WB_PC4;
            end
            OPCODE_JALR: begin
                ctrl_o.regwren  = 1'b1;
                ctrl_o.op_b_imm = 1'b1;           // ALU forms rs1 + imm
                ctrl_o.br_op    = BR_JALR;
                ctrl_o.wb_sel   = WB_PC4;
            end
            OPCODE_LUI: begin
                ctrl_o.regwren  = 1'b1;
                ctrl_o.op_b_imm = 1'b1;
                ctrl_o.alu_op   = ALU_LUI;
            end
            OPCODE_AUIPC: begin
                ctrl_o.regwren  = 1'b1;
                ctrl_o.op_b_imm = 1'b1;
                ctrl_o.alu_op   = ALU_AUIPC;      // PC + U immediate
            end
            default: begin
                ctrl_o = CTRL_NOP;
            end
        endcase
    end

endmodule : control

// ==== core_ctrl_pkg.sv ====
/*
 * Decoded control bundle of the single-cycle core
 * An all-zero bundle is a no-op with no writes, PC+4 and ALU add
 */
package core_ctrl_pkg;

    // Write-back source
    typedef enum logic [1:0] {
        WB_ALU = 2'b00,                           // ALU result and the no-op value
        WB_MEM = 2'b01,                           // Load data
        WB_PC4 = 2'b10                            // Link address for JAL/JALR
    } wb_sel_e;

    typedef struct packed {
        logic                  regwren;           // Write rd at the clock edge
        logic                  memren;            // Load strobe
        logic                  memwren;           // Store strobe
        logic                  op_b_imm;          // ALU operand B is the immediate
        riscv_isa_pkg::alu_op_e alu_op;
        riscv_isa_pkg::br_op_e  br_op;            // Next-PC rule for pc_unit
        wb_sel_e               wb_sel;
    } ctrl_t;

    // Bundle used for unknown opcodes
    localparam ctrl_t CTRL_NOP = '{
        regwren:  1'b0,
        memren:   1'b0,
        memwren:  1'b0,
        op_b_imm: 1'b0,
        alu_op:   riscv_isa_pkg::ALU_ADD,
        br_op:    riscv_isa_pkg::BR_NONE,
        wb_sel:   WB_ALU
    };

endpackage : core_ctrl_pkg

// ==== core_top.sv ====
/*
 * Single-cycle RV32I core, one instruction per clock
 * Instruction and data memories must answer combinationally
 * Memory strobes are only valid while arst_n_i is high
 */
`timescale 1ns/1ps

module core_top #(
    parameter int                DWIDTH   = riscv_isa_pkg::XLEN,
    parameter logic [DWIDTH-1:0] RESET_PC = '0
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    output logic [DWIDTH-1:0] imem_addr_o,  // Current PC
    input  logic [DWIDTH-1:0] imem_rdata_i, // Same-cycle instruction
    output logic [DWIDTH-1:0] dmem_addr_o,
    output logic [DWIDTH-1:0] dmem_wdata_o,
    output logic              dmem_we_o,    // Captured at the next rising edge
    output logic              dmem_re_o,
    input  logic [DWIDTH-1:0] dmem_rdata_i  // Same-cycle load data
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    ctrl_t             ctrl;
    logic [DWIDTH-1:0] insn;
    logic [DWIDTH-1:0] imm;
    logic [DWIDTH-1:0] rs1_data;
    logic [DWIDTH-1:0] rs2_data;
    logic [DWIDTH-1:0] op_b;
    logic [DWIDTH-1:0] alu_res;
    logic [DWIDTH-1:0] pc;
    logic [DWIDTH-1:0] pc_plus4;
    logic [DWIDTH-1:0] wb_data;

    assign insn = imem_rdata_i;

    control u_control (
        .opcode_i (opcode_e'(insn[6:0])),
        .funct3_i (insn[14:12]),
        .funct7_i (insn[31:25]),
        .ctrl_o   (ctrl)
    );

    imm_gen u_imm_gen (
        .insn_i (insn),
        .imm_o  (imm)
    );

    regfile #(.DWIDTH(DWIDTH)) u_regfile (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (insn[19:15]),
        .rs2_addr_i (insn[24:20]),
        .rd_addr_i  (insn[11:7]),
        .rd_we_i    (ctrl.regwren),         // x0 filtered inside
        .rd_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    assign op_b = ctrl.op_b_imm ? imm : rs2_data; // Operand B select

    alu #(.DWIDTH(DWIDTH)) u_alu (
        .op_i  (ctrl.alu_op),
        .a_i   (rs1_data),
        .b_i   (op_b),
        .pc_i  (pc),
        .res_o (alu_res)
    );

    pc_unit #(.DWIDTH(DWIDTH), .RESET_PC(RESET_PC)) u_pc_unit (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .br_op_i    (ctrl.br_op),
        .rs1_i      (rs1_data),
        .rs2_i      (rs2_data),
        .imm_i      (imm),
        .alu_res_i  (alu_res),
        .pc_o       (pc),
        .pc_plus4_o (pc_plus4)
    );

    // Write-back select
    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  wb_data = dmem_rdata_i;
            WB_PC4:  wb_data = pc_plus4;    // Link address
            default: wb_data = alu_res;
        endcase
    end

    assign imem_addr_o  = pc;
    assign dmem_addr_o  = alu_res;          // Word access, no alignment check
    assign dmem_wdata_o = rs2_data;
    assign dmem_we_o    = ctrl.memwren;
    assign dmem_re_o    = ctrl.memren;

endmodule : core_top

// ==== imm_gen.sv ====
/*
 * Immediate generator for the RV32I formats
 * Assumes XLEN is 32; formats without an immediate give zero
 */
`timescale 1ns/1ps

module imm_gen (
    input  logic [riscv_isa_pkg::XLEN-1:0] insn_i,
    output logic [riscv_isa_pkg::XLEN-1:0] imm_o
);
    import riscv_isa_pkg::*;

    opcode_e opcode;                              // Format follows the opcode
    logic    sgn;                                 // Sign bit, always insn[31]

    assign opcode = opcode_e'(insn_i[6:0]);
    assign sgn    = insn_i[31];

    always_comb begin
        case (opcode)
            OPCODE_ITYPE, OPCODE_LOAD, OPCODE_JALR: begin
                imm_o = {{(XLEN-12){sgn}}, insn_i[31:20]}; // I-type
            end
            OPCODE_STORE: begin
                imm_o = {{(XLEN-12){sgn}}, insn_i[31:25], insn_i[11:7]}; // S-type
            end
            OPCODE_BRANCH: begin
                // B-type, bit 0 implied zero
                imm_o = {{(XLEN-13){sgn}}, insn_i[31], insn_i[7],
                         insn_i[30:25], insn_i[11:8], 1'b0};
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                imm_o = {insn_i[31:12], 12'b0};   // U-type, low bits zero
            end
            OPCODE_JAL: begin
                // J-type, halfword offset
                imm_o = {{(XLEN-21){sgn}}, insn_i[31], insn_i[19:12],
                         insn_i[20], insn_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;                       // R-type and unknown
            end
        endcase
    end

endmodule : imm_gen

// ==== pc_unit.sv ====
/*
 * Program counter with branch resolution and next-PC select
 * No alignment check; JALR clears only bit 0 of the target
 */
`timescale 1ns/1ps

module pc_unit #(
    parameter int                DWIDTH   = riscv_isa_pkg::XLEN,
    parameter logic [DWIDTH-1:0] RESET_PC = '0
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  riscv_isa_pkg::br_op_e br_op_i,
    input  logic [DWIDTH-1:0]     rs1_i,
    input  logic [DWIDTH-1:0]     rs2_i,
    input  logic [DWIDTH-1:0]     imm_i,      // B or J immediate
    input  logic [DWIDTH-1:0]     alu_res_i,  // rs1 + imm for JALR
    output logic [DWIDTH-1:0]     pc_o,
    output logic [DWIDTH-1:0]     pc_plus4_o
);
    import riscv_isa_pkg::*;

    logic              taken;                 // Redirect to PC + imm
    logic [DWIDTH-1:0] pc_next;

    always_comb begin
        case (br_op_i)
            BR_EQ:   taken = (rs1_i == rs2_i);
            BR_NE:   taken = (rs1_i != rs2_i);
            BR_LT:   taken = ($signed(rs1_i) < $signed(rs2_i));
            BR_GE:   taken = ($signed(rs1_i) >= $signed(rs2_i));
            BR_LTU:  taken = (rs1_i < rs2_i);
            BR_GEU:  taken = (rs1_i >= rs2_i);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;            // NONE, and JALR handled below
        endcase
    end

    assign pc_plus4_o = pc_o + DWIDTH'(4);

    always_comb begin
        if (br_op_i == BR_JALR) begin
            pc_next = {alu_res_i[DWIDTH-1:1], 1'b0}; // Bit 0 cleared
        end else if (taken) begin
            pc_next = pc_o + imm_i;
        end else begin
            pc_next = pc_plus4_o;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_o <= RESET_PC;
        end else begin
            pc_o <= pc_next;
        end
    end

endmodule : pc_unit

// ==== regfile.sv ====
/*
 * 32 x DWIDTH register file, two combinational reads, one write
 * x0 reads as zero and ignores writes
 */
`timescale 1ns/1ps

module regfile #(
    parameter int DWIDTH = riscv_isa_pkg::XLEN
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic [4:0]        rs1_addr_i,
    input  logic [4:0]        rs2_addr_i,
    input  logic [4:0]        rd_addr_i,
    input  logic              rd_we_i,        // Write at the rising edge
    input  logic [DWIDTH-1:0] rd_data_i,
    output logic [DWIDTH-1:0] rs1_data_o,
    output logic [DWIDTH-1:0] rs2_data_o
);

    logic [DWIDTH-1:0] regs [31:1];           // No storage for x0

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;                // Architectural state starts at zero
            end
        end else if (rd_we_i && (rd_addr_i != 5'd0)) begin
            regs[rd_addr_i] <= rd_data_i;     // x0 writes dropped
        end
    end

    // Combinational reads, no write-through needed in one cycle
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

endmodule : regfile

// ==== riscv_isa_pkg.sv ====
/*
 * RV32I encodings shared by the decoder, immediate generator and datapath
 * Only the base integer opcodes used by this core are listed
 * XLEN is fixed at 32, the immediate generator relies on it
 */
package riscv_isa_pkg;

    localparam int XLEN = 32;                     // Data and address width

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPCODE_RTYPE  = 7'b0110011,               // Register-register ALU
        OPCODE_ITYPE  = 7'b0010011,               // Register-immediate ALU
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111
    } opcode_e;

    // ALU funct3 values
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // Branch funct3 values
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    localparam logic [6:0] FUNCT7_SUB_SRA = 7'b0100000; // Bit 30 set, SUB and SRA/SRAI

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    // Nine values, so four bits are needed
    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } br_op_e;

endpackage : riscv_isa_pkg

// ==== run.sh ====
#!/usr/bin/env bash
# Build tb_core with Verilator, run it and judge the result from sim.log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core -f sim.f -o tb_core_sim \
    && ./obj_dir/tb_core_sim | tee sim.log \
    || { echo "Build or simulation error"; exit 1; }

grep -q ">>> FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log && echo "Simulation passed" \
    || { echo "No result found in sim.log"; exit 1; }

// ==== sim.f ====
riscv_isa_pkg.sv
core_ctrl_pkg.sv
control.sv
imm_gen.sv
regfile.sv
alu.sv
pc_unit.sv
core_top.sv
tb_clkgen.sv
tb_core.sv

// ==== tb_clkgen.sv ====
/*
 * Testbench clock and reset source
 * Reset is released 1 ns after the last reset edge, never on an edge
 */
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS  = 4,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;    // 50% duty
    end

    initial begin
        arst_n_o = 1'b0;                             // Asserted from time zero
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 arst_n_o = 1'b1;                          // Small hold after the edge
    end

endmodule : tb_clkgen

// ==== tb_core.sv ====
/*
 * Testbench for core_top, random RV32I program against an ISA model
 * Assumes RESET_PC of zero, a 1 KiB program window and a 256-byte data window
 * Control flow only goes forward, so the run ends on the final self-jump
 */
`timescale 1ns/1ps

module tb_core;
    import riscv_isa_pkg::*;

    localparam int          CLK_PERIOD  = 4;
    localparam int          RST_CYCLES  = 4;
    localparam int          PROG_LEN    = 200;          // Generated instructions
    localparam int          DMEM_WORDS  = 64;           // 256-byte data window
    localparam logic [31:0] RESET_PC    = 32'h0;
    localparam logic [31:0] END_PC      = RESET_PC + 32'((PROG_LEN - 1) * 4);
    localparam int          WATCHDOG_NS = (RST_CYCLES + PROG_LEN + 50) * CLK_PERIOD;

    logic        clk_i;
    logic        arst_n_i;
    logic [31:0] imem_addr_o;
    logic [31:0] imem_rdata_i;
    logic [31:0] dmem_addr_o;
    logic [31:0] dmem_wdata_o;
    logic        dmem_we_o;
    logic        dmem_re_o;
    logic [31:0] dmem_rdata_i;

    logic [31:0] imem   [256];                          // Program, fixed after time 0
    logic [31:0] dmem   [DMEM_WORDS];                   // Data memory seen by the DUT
    logic [31:0] m_dmem [DMEM_WORDS];                   // Model copy
    logic [31:0] m_regs [32];
    logic [31:0] m_pc;
    integer      seed;
    int          errors;
    int          checks;
    int          m_stores;
    int          dut_stores;

    tb_clkgen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) u_clkgen (
        .clk_o    (clk_i),
        .arst_n_o (arst_n_i)
    );

    core_top #(.DWIDTH(32), .RESET_PC(RESET_PC)) DUT (.*);

    // Both memories answer within the cycle
    assign imem_rdata_i = imem[imem_addr_o[9:2]];
    assign dmem_rdata_i = dmem[dmem_addr_o[7:2]];

    // Initial data pattern, distinct for every word address
    function automatic logic [31:0] fill_word(input int idx);
        return 32'h9e3779b9 * 32'(idx + 1);
    endfunction

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= fill_word(i);
            end
            dut_stores <= 0;                            // Strobes ignored in reset
        end else if (dmem_we_o) begin
            dmem[dmem_addr_o[7:2]] <= dmem_wdata_o;     // Captured at the closing edge
            dut_stores <= dut_stores + 1;
        end
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // RV32I ALU result from funct3 and the bit-30 alternate form
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) return $unsigned($signed(a) >>> b[4:0]);
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH time=%0t %s expected=%h got=%h", $time, name, exp, got);
        end
    endtask

    task automatic build_program();
        int          kind;
        int          span;
        int          skip;                              // Forward distance in words
        logic [2:0]  f3;
        logic [4:0]  rd, rs1, rs2;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [12:0] boff;
        logic [20:0] joff;
        for (int i = 0; i < 256; i++) begin
            imem[i] = {12'(i), 5'd0, 3'b000, 5'd0, OPCODE_ITYPE}; // ADDI x0 tagged by index
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            kind  = rand_below(14);
            f3    = 3'(rand_below(8));
            rd    = 5'(rand_below(8));                  // x0..x7, frequent reuse
            rs1   = 5'(rand_below(8));
            rs2   = 5'(rand_below(8));
            imm12 = 12'($random(seed));
            f7    = (rand_below(2) == 1 && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
            span  = (PROG_LEN - 1 - i > 4) ? 4 : PROG_LEN - 1 - i;
            skip  = (span > 0) ? 1 + rand_below(span) : 0;
            boff  = 13'(skip * 4);
            joff  = 21'(skip * 4);
            if (i == 0) begin
                imem[i] = {imm12, 5'd0, 3'b000, 5'd1, OPCODE_ITYPE}; // ADDI x1
            end else if (i == PROG_LEN - 1) begin
                imem[i] = {20'd0, 5'd0, OPCODE_JAL};        // Jump to itself
            end else begin
                case (kind)
                    0, 1, 2: imem[i] = {f7, rs2, rs1, f3, rd, OPCODE_RTYPE};
                    3, 4: begin
                        if (f3 == 3'b001 || f3 == 3'b101) begin
                            imm12 = {f7, imm12[4:0]};       // Shift form
                        end
                        imem[i] = {imm12, rs1, f3, rd, OPCODE_ITYPE};
                    end
                    5: imem[i] = {20'($random(seed)), rd, OPCODE_LUI};
                    6: imem[i] = {20'($random(seed)), rd, OPCODE_AUIPC};
                    7: imem[i] = {12'(rand_below(DMEM_WORDS) * 4), 5'd0, 3'b010, rd, OPCODE_LOAD};
                    8, 9: begin
                        imm12   = 12'(rand_below(DMEM_WORDS) * 4);
                        imem[i] = {imm12[11:5], rs2, 5'd0, 3'b010, imm12[4:0], OPCODE_STORE};
                    end
                    10, 11: begin
                        f3      = (f3[2:1] == 2'b01) ? {2'b00, f3[0]} : f3; // 010/011 reserved
                        imem[i] = {boff[12], boff[10:5], rs2, rs1, f3,
                                   boff[4:1], boff[11], OPCODE_BRANCH};
                    end
                    12: imem[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPCODE_JAL};
                    default: begin
                        // Absolute target through x0, imm bit 0 random
                        imm12   = 12'(RESET_PC) + 12'((i + skip) * 4) + 12'(rand_below(2));
                        imem[i] = {imm12, 5'd0, 3'b000, rd, OPCODE_JALR};
                    end
                endcase
            end
        end
    endtask

    // Compare the DUT with the model's current instruction, then retire it
    task automatic check_and_step();
        logic [31:0] insn, a, b, imm_i, imm_s, res, addr, next_pc;
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic        wr;
        logic        taken;
        insn    = imem[m_pc[9:2]];
        op      = insn[6:0];
        f3      = insn[14:12];
        rd      = insn[11:7];
        a       = m_regs[insn[19:15]];
        b       = m_regs[insn[24:20]];
        imm_i   = {{20{insn[31]}}, insn[31:20]};
        imm_s   = {{20{insn[31]}}, insn[31:25], insn[11:7]};
        res     = '0;
        wr      = 1'b1;                                 // Most opcodes write rd
        taken   = 1'b0;
        next_pc = m_pc + 32'd4;
        check_value("imem_addr_o", imem_addr_o, m_pc);
        check_value("dmem_we_o", 32'(dmem_we_o), 32'(op == OPCODE_STORE));
        check_value("dmem_re_o", 32'(dmem_re_o), 32'(op == OPCODE_LOAD));
        case (op)
            OPCODE_RTYPE: res = ref_alu(f3, insn[30], a, b);
            OPCODE_ITYPE: res = ref_alu(f3, insn[30] && f3 == 3'b101, a, imm_i); // No SUBI
            OPCODE_LUI:   res = {insn[31:12], 12'b0};
            OPCODE_AUIPC: res = m_pc + {insn[31:12], 12'b0};
            OPCODE_LOAD: begin
                addr = a + imm_i;
                res  = m_dmem[addr[7:2]];
            end
            OPCODE_STORE: begin
                wr   = 1'b0;
                addr = a + imm_s;
                check_value("dmem_addr_o", dmem_addr_o, addr);
                check_value("dmem_wdata_o", dmem_wdata_o, b);
                m_dmem[addr[7:2]] = b;
                m_stores++;
            end
            OPCODE_BRANCH: begin
                wr = 1'b0;
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = m_pc + {{19{insn[31]}}, insn[31], insn[7],
                                      insn[30:25], insn[11:8], 1'b0};
                end
            end
            OPCODE_JAL: begin
                res     = m_pc + 32'd4;
                next_pc = m_pc + {{11{insn[31]}}, insn[31], insn[19:12],
                                  insn[20], insn[30:21], 1'b0};
            end
            OPCODE_JALR: begin
                res     = m_pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;         // Bit 0 dropped
            end
            default: wr = 1'b0;                         // Unknown opcode, no-op
        endcase
        if (wr && rd != 5'd0) begin
            m_regs[rd] = res;
        end
        m_pc = next_pc;
    endtask

    initial begin
        seed     = 32'hd020;
        errors   = 0;
        checks   = 0;
        m_stores = 0;
        m_pc     = RESET_PC;
        build_program();
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            m_dmem[i] = fill_word(i);
        end
        wait (arst_n_i === 1'b1);
        @(negedge clk_i);                               // Mid-cycle, outputs settled
        check_value("imem_addr_o at reset exit", imem_addr_o, RESET_PC);
        check_value("dmem_we_o at reset exit", 32'(dmem_we_o), 32'd0);
        while (m_pc != END_PC) begin
            check_and_step();
            @(negedge clk_i);
        end
        repeat (2) begin                                // Self-jump holds the PC
            check_and_step();
            @(negedge clk_i);
        end
        check_value("store_count", 32'(dut_stores), 32'(m_stores));
        $display("checks=%0d errors=%0d stores=%0d", checks, errors, m_stores);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Reset plus one cycle per instruction and some margin
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: program did not reach its final jump within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule : tb_core
